// ==== filelist.f ====
rtl/exu_pkg.sv
rtl/exu_int_alu.sv
rtl/exu_agu.sv
rtl/exu_branch_unit.sv
rtl/exu_lsu_reg.sv
rtl/exu_top.sv
verif/exu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 -f filelist.f --top-module exu_tb -o exu_sim \
    && ./obj_dir/exu_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Test passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/exu_tb.sv ====
`timescale 1ns/10ps

module exu_tb;

    typedef struct {
        logic [exu_pkg::op_w-1:0] op;
        logic [31:0]              src1;
        logic [31:0]              src2;
        logic [31:0]              imm;
        logic [31:0]              pc;
        logic                     wb_vld;
        logic                     taken;
        logic                     stall;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        issue_vld;
    logic [4:0]  issue_op;
    logic [31:0] issue_src1;
    logic [31:0] issue_src2;
    logic [31:0] issue_imm;
    logic [31:0] issue_pc;
    logic        issue_wb_vld;
    logic [4:0]  issue_wb_addr;
    logic        issue_rdy;
    logic        wb_vld;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        wb_is_load;
    logic        redirect_vld;
    logic [11:0] redirect_addr;
    logic        flush_vld;
    logic        lsu_rdy;
    logic        lsu_vld;
    logic        lsu_wb_vld;
    logic [4:0]  lsu_op;
    logic [4:0]  lsu_wb_addr;
    logic [31:0] lsu_wb_data;
    logic [31:0] lsu_st_data;
    logic [12:0] lsu_sram_addr;
    logic        lsu_ld_iram;
    logic        lsu_ld_wram;
    logic        lsu_ld_oram;
    logic        lsu_st_iram;
    logic        lsu_st_wram;
    logic        lsu_st_oram;

    entry_t tbl[$];

    exu_top #(.redirect_w(12)) u_exu_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic op_is_load(logic [4:0] op);
        return op == exu_pkg::op_lb || op == exu_pkg::op_lh || op == exu_pkg::op_lw ||
               op == exu_pkg::op_lbu || op == exu_pkg::op_lhu;
    endfunction

    function automatic logic op_is_store(logic [4:0] op);
        return op == exu_pkg::op_sb || op == exu_pkg::op_sh || op == exu_pkg::op_sw;
    endfunction

    function automatic logic op_is_branch(logic [4:0] op);
        return op >= exu_pkg::op_beq && op <= exu_pkg::op_bgeu;
    endfunction

    // rv32i write-back value, zero for ops without one
    function automatic logic [31:0] alu_result(entry_t e);
        case (e.op)
            exu_pkg::op_add:   return e.src1 + e.src2;
            exu_pkg::op_sub:   return e.src1 - e.src2;
            exu_pkg::op_slt:   return {31'd0, $signed(e.src1) < $signed(e.src2)};
            exu_pkg::op_sltu:  return {31'd0, e.src1 < e.src2};
            exu_pkg::op_xor:   return e.src1 ^ e.src2;
            exu_pkg::op_or:    return e.src1 | e.src2;
            exu_pkg::op_and:   return e.src1 & e.src2;
            exu_pkg::op_sll:   return e.src1 << e.src2[4:0];
            exu_pkg::op_srl:   return e.src1 >> e.src2[4:0];
            exu_pkg::op_sra:   return $unsigned($signed(e.src1) >>> e.src2[4:0]);
            exu_pkg::op_lui:   return e.src2;
            exu_pkg::op_auipc: return e.pc + e.src2;
            exu_pkg::op_jal:   return e.pc + 32'd4;
            exu_pkg::op_jalr:  return e.pc + 32'd4;
            default:           return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] jump_target(entry_t e);
        if (e.op == exu_pkg::op_jal) begin
            return e.pc + e.src2;
        end else if (e.op == exu_pkg::op_jalr) begin
            return e.src1 + e.src2;
        end
        return e.pc + e.imm;
    endfunction

    function automatic logic [31:0] mem_address(entry_t e);
        return e.src1 + (op_is_store(e.op) ? e.imm : e.src2);
    endfunction

    function automatic logic [127:0] lsu_state();
        return 128'({lsu_vld, lsu_wb_vld, lsu_op, lsu_wb_addr, lsu_wb_data, lsu_st_data,
                     lsu_sram_addr, lsu_ld_iram, lsu_ld_wram, lsu_ld_oram,
                     lsu_st_iram, lsu_st_wram, lsu_st_oram});
    endfunction

    task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_on_timeout(string what);
        $display("timeout while waiting for %s", what);
        $display("Test failed");
        $fatal(1, "wait expired");
    endtask

    task automatic wait_issue_rdy();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (issue_rdy !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (issue_rdy !== 1'b1) begin
            stop_on_timeout("issue_rdy");
        end
    endtask

    task automatic wait_lsu_vld(output int cycles);
        cycles = 0;
        while (lsu_vld !== 1'b1 && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        if (lsu_vld !== 1'b1) begin
            stop_on_timeout("lsu_vld");
        end
    endtask

    task automatic check_idle_flags();
        check_val("redirect_vld", 128'(redirect_vld), 128'(0));
        check_val("flush_vld", 128'(flush_vld), 128'(0));
        check_val("lsu_vld", 128'(lsu_vld), 128'(0));
        check_val("lsu_wb_vld", 128'(lsu_wb_vld), 128'(0));
    endtask

    task automatic add_entry(logic [4:0] op, logic [31:0] src1, logic [31:0] src2,
                             logic [31:0] imm, logic [31:0] pc, logic wbv, logic tk,
                             logic st);
        entry_t e;
        e = '{op, src1, src2, imm, pc, wbv, tk, st};
        tbl.push_back(e);
    endtask

    task automatic run_entry(entry_t e, int idx);
        logic [31:0]  eff;
        logic [31:0]  tgt;
        logic [1:0]   ty;
        logic         ld;
        logic         st;
        logic [127:0] held;
        int           lat;
        eff = mem_address(e);
        tgt = jump_target(e);
        ty  = eff[exu_pkg::sram_type_lsb +: 2];
        ld  = op_is_load(e.op);
        st  = op_is_store(e.op);
        @(posedge clk);
        issue_vld     <= 1'b1;
        issue_op      <= e.op;
        issue_src1    <= e.src1;
        issue_src2    <= e.src2;
        issue_imm     <= e.imm;
        issue_pc      <= e.pc;
        issue_wb_vld  <= e.wb_vld;
        issue_wb_addr <= idx[4:0];
        lsu_rdy       <= 1'b1;
        wait_issue_rdy();
        // previous entry must be gone before this one fires
        check_val("lsu_vld", 128'(lsu_vld), 128'(0));
        check_val("wb_vld", 128'(wb_vld), 128'(e.wb_vld));
        check_val("wb_addr", 128'(wb_addr), 128'(idx[4:0]));
        check_val("wb_data", 128'(wb_data), 128'(alu_result(e)));
        check_val("wb_is_load", 128'(wb_is_load), 128'(ld));
        @(posedge clk);
        // a taken entry stays on issue into the redirect cycle
        issue_vld <= e.taken;
        if (e.taken) begin
            issue_wb_vld <= 1'b1;
        end
        if (e.stall) begin
            lsu_rdy <= 1'b0;
        end
        @(negedge clk);
        check_val("redirect_vld", 128'(redirect_vld), 128'(e.taken));
        check_val("flush_vld", 128'(flush_vld), 128'(e.taken));
        if (e.taken) begin
            check_val("redirect_addr", 128'(redirect_addr), 128'(tgt[11:0]));
            check_val("shadow wb_vld", 128'(wb_vld), 128'(0));
        end
        if (op_is_branch(e.op)) begin
            check_val("lsu_vld", 128'(lsu_vld), 128'(0));
        end else begin
            wait_lsu_vld(lat);
            check_val("lsu_vld latency", 128'(lat), 128'(0));
            check_val("lsu_wb_vld", 128'(lsu_wb_vld), 128'(e.wb_vld));
            check_val("lsu_op", 128'(lsu_op), 128'(e.op));
            check_val("lsu_wb_addr", 128'(lsu_wb_addr), 128'(idx[4:0]));
            check_val("lsu_wb_data", 128'(lsu_wb_data), 128'(alu_result(e)));
            check_val("lsu_st_data", 128'(lsu_st_data), 128'(e.src2));
            check_val("lsu_sram_addr", 128'(lsu_sram_addr), 128'(eff[12:0]));
            check_val("lsu ld/st selects",
                      128'({lsu_ld_iram, lsu_ld_wram, lsu_ld_oram,
                            lsu_st_iram, lsu_st_wram, lsu_st_oram}),
                      128'({ld && ty == exu_pkg::sram_iram, ld && ty == exu_pkg::sram_wram,
                            ld && ty == exu_pkg::sram_oram, st && ty == exu_pkg::sram_iram,
                            st && ty == exu_pkg::sram_wram, st && ty == exu_pkg::sram_oram}));
        end
        // the instruction behind a redirect gets dropped
        if (e.taken) begin
            @(posedge clk);
            issue_vld <= 1'b0;
            @(negedge clk);
            check_val("shadow lsu_vld", 128'(lsu_vld), 128'(0));
            check_val("redirect_vld", 128'(redirect_vld), 128'(0));
        end
        if (e.stall) begin
            held = lsu_state();
            repeat ($urandom_range(4, 1)) begin
                @(posedge clk);
                issue_vld     <= 1'b1;
                issue_wb_vld  <= 1'b1;
                issue_wb_addr <= ~idx[4:0];
                @(negedge clk);
                check_val("issue_rdy", 128'(issue_rdy), 128'(0));
                check_val("wb_vld", 128'(wb_vld), 128'(0));
                check_val("lsu outputs", lsu_state(), held);
            end
            @(posedge clk);
            issue_vld <= 1'b0;
            lsu_rdy   <= 1'b1;
            @(negedge clk);
            check_val("lsu outputs", lsu_state(), held);
        end
    endtask

    task automatic fill_table();
        // op, src1, src2, imm, pc, wb_vld, taken, stall
        add_entry(exu_pkg::op_add, 32'h5, 32'h3, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_sub, 32'h3, 32'h5, 32'h0, 32'h0, 1'b1, 1'b0, 1'b1);
        add_entry(exu_pkg::op_slt, 32'hfffffff0, 32'h5, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_slt, 32'h5, 32'h80000000, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_sltu, 32'hfffffff0, 32'h5, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_sltu, 32'h5, 32'hfffffff0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b1);
        add_entry(exu_pkg::op_xor, 32'ha5a5a5a5, 32'h0ff00ff0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_or, 32'ha5a5a5a5, 32'h0ff00ff0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_and, 32'ha5a5a5a5, 32'h0ff00ff0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_sll, 32'h3, 32'h25, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_srl, 32'h80000000, 32'h3f, 32'h0, 32'h0, 1'b1, 1'b0, 1'b1);
        add_entry(exu_pkg::op_sra, 32'h80000000, 32'h24, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_lui, 32'h0, 32'h12345000, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_auipc, 32'h0, 32'h2000, 32'h0, 32'h1000, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_beq, 32'h7, 32'h7, 32'h40, 32'h400, 1'b0, 1'b1, 1'b0);
        add_entry(exu_pkg::op_bne, 32'h7, 32'h7, 32'h40, 32'h400, 1'b0, 1'b0, 1'b0);
        add_entry(exu_pkg::op_blt, 32'hffffffff, 32'h1, 32'h40, 32'h400, 1'b0, 1'b1, 1'b0);
        add_entry(exu_pkg::op_bge, 32'h5, 32'h5, 32'h40, 32'h400, 1'b0, 1'b1, 1'b0);
        add_entry(exu_pkg::op_bge, 32'hffffffff, 32'h1, 32'h40, 32'h400, 1'b0, 1'b0, 1'b1);
        add_entry(exu_pkg::op_bltu, 32'h1, 32'hffffffff, 32'h40, 32'h400, 1'b0, 1'b1, 1'b0);
        add_entry(exu_pkg::op_bgeu, 32'h1, 32'hffffffff, 32'h40, 32'h400, 1'b0, 1'b0, 1'b0);
        add_entry(exu_pkg::op_jal, 32'h0, 32'h123, 32'h0, 32'h800, 1'b1, 1'b1, 1'b0);
        add_entry(exu_pkg::op_jalr, 32'h1000, 32'hab, 32'h0, 32'h200, 1'b1, 1'b1, 1'b0);
        // type field in bits 14:13 walks through all four codes
        add_entry(exu_pkg::op_lw, 32'h0, 32'h10, 32'h100, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_lb, 32'h2000, 32'h4, 32'h100, 32'h0, 1'b1, 1'b0, 1'b1);
        add_entry(exu_pkg::op_lhu, 32'h4000, 32'h1ffc, 32'h100, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_lh, 32'h6000, 32'h8, 32'h100, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_lbu, 32'hfffff000, 32'h1234, 32'h100, 32'h0, 1'b1, 1'b0, 1'b0);
        add_entry(exu_pkg::op_sw, 32'h4000, 32'hdeadbeef, 32'h4, 32'h0, 1'b0, 1'b0, 1'b1);
        add_entry(exu_pkg::op_sb, 32'h2000, 32'ha5, 32'h1fff, 32'h0, 1'b0, 1'b0, 1'b0);
        add_entry(exu_pkg::op_sh, 32'h6000, 32'hbeef, 32'h2000, 32'h0, 1'b0, 1'b0, 1'b0);
        add_entry(exu_pkg::op_sw, 32'h6000, 32'h12345678, 32'h4, 32'h0, 1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h7ce8_999e));
        reset         <= 1'b1;
        issue_vld     <= 1'b0;
        issue_op      <= '0;
        issue_src1    <= '0;
        issue_src2    <= '0;
        issue_imm     <= '0;
        issue_pc      <= '0;
        issue_wb_vld  <= 1'b0;
        issue_wb_addr <= '0;
        lsu_rdy       <= 1'b1;
        fill_table();
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i == 9) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            check_idle_flags();
        end
        @(posedge clk);
        @(negedge clk);
        check_idle_flags();
        foreach (tbl[i]) begin
            run_entry(tbl[i], i);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== rtl/exu_top.sv ====
`timescale 1ns/10ps

module exu_top #(
    parameter int redirect_w = 12
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            issue_vld,
    input  logic [exu_pkg::op_w-1:0]        issue_op,
    input  logic [exu_pkg::xlen-1:0]        issue_src1,
    input  logic [exu_pkg::xlen-1:0]        issue_src2,
    input  logic [exu_pkg::xlen-1:0]        issue_imm,
    input  logic [exu_pkg::xlen-1:0]        issue_pc,
    input  logic                            issue_wb_vld,
    input  logic [exu_pkg::reg_addr_w-1:0]  issue_wb_addr,
    output logic                            issue_rdy,
    output logic                            wb_vld,
    output logic [exu_pkg::reg_addr_w-1:0]  wb_addr,
    output logic [exu_pkg::xlen-1:0]        wb_data,
    output logic                            wb_is_load,
    output logic                            redirect_vld,
    output logic [redirect_w-1:0]           redirect_addr,
    output logic                            flush_vld,
    input  logic                            lsu_rdy,
    output logic                            lsu_vld,
    output logic                            lsu_wb_vld,
    output logic [exu_pkg::op_w-1:0]        lsu_op,
    output logic [exu_pkg::reg_addr_w-1:0]  lsu_wb_addr,
    output logic [exu_pkg::xlen-1:0]        lsu_wb_data,
    output logic [exu_pkg::xlen-1:0]        lsu_st_data,
    output logic [exu_pkg::sram_addr_w-1:0] lsu_sram_addr,
    output logic                            lsu_ld_iram,
    output logic                            lsu_ld_wram,
    output logic                            lsu_ld_oram,
    output logic                            lsu_st_iram,
    output logic                            lsu_st_wram,
    output logic                            lsu_st_oram
);

    exu_pkg::eff_word_u              alu_wb;
    logic                            issue_fire;
    logic [exu_pkg::sram_addr_w-1:0] sram_addr;
    logic                            ld_iram;
    logic                            ld_wram;
    logic                            ld_oram;
    logic                            st_iram;
    logic                            st_wram;
    logic                            st_oram;

    assign issue_rdy  = lsu_rdy;
    assign flush_vld  = redirect_vld;

    // bypass toward decode in the fire cycle
    assign wb_vld     = issue_fire & issue_wb_vld;
    assign wb_addr    = issue_wb_addr;
    assign wb_data    = alu_wb.raw;
    assign wb_is_load = exu_pkg::is_load(issue_op);

    exu_int_alu u_int_alu (
        .op      (issue_op),
        .src1    (issue_src1),
        .src2    (issue_src2),
        .pc      (issue_pc),
        .wb_data (alu_wb)
    );

    exu_agu u_agu (
        .op        (issue_op),
        .src1      (issue_src1),
        .src2      (issue_src2),
        .imm       (issue_imm),
        .sram_addr (sram_addr),
        .ld_iram   (ld_iram),
        .ld_wram   (ld_wram),
        .ld_oram   (ld_oram),
        .st_iram   (st_iram),
        .st_wram   (st_wram),
        .st_oram   (st_oram)
    );

    exu_branch_unit #(
        .redirect_w (redirect_w)
    ) u_branch_unit (
        .clk           (clk),
        .reset         (reset),
        .issue_vld     (issue_vld),
        .lsu_rdy       (lsu_rdy),
        .op            (issue_op),
        .src1          (issue_src1),
        .src2          (issue_src2),
        .imm           (issue_imm),
        .pc            (issue_pc),
        .issue_fire    (issue_fire),
        .redirect_vld  (redirect_vld),
        .redirect_addr (redirect_addr)
    );

    exu_lsu_reg u_lsu_reg (
        .clk           (clk),
        .reset         (reset),
        .issue_fire    (issue_fire),
        .lsu_rdy       (lsu_rdy),
        .op            (issue_op),
        .wb_vld_in     (wb_vld),
        .wb_addr_in    (issue_wb_addr),
        .wb_data_in    (alu_wb.raw),
        .src2          (issue_src2),
        .sram_addr_in  (sram_addr),
        .ld_iram_in    (ld_iram),
        .ld_wram_in    (ld_wram),
        .ld_oram_in    (ld_oram),
        .st_iram_in    (st_iram),
        .st_wram_in    (st_wram),
        .st_oram_in    (st_oram),
        .lsu_vld       (lsu_vld),
        .lsu_wb_vld    (lsu_wb_vld),
        .lsu_op        (lsu_op),
        .lsu_wb_addr   (lsu_wb_addr),
        .lsu_wb_data   (lsu_wb_data),
        .lsu_st_data   (lsu_st_data),
        .lsu_sram_addr (lsu_sram_addr),
        .lsu_ld_iram   (lsu_ld_iram),
        .lsu_ld_wram   (lsu_ld_wram),
        .lsu_ld_oram   (lsu_ld_oram),
        .lsu_st_iram   (lsu_st_iram),
        .lsu_st_wram   (lsu_st_wram),
        .lsu_st_oram   (lsu_st_oram)
    );

endmodule

// ==== rtl/exu_lsu_reg.sv ====
`timescale 1ns/10ps

module exu_lsu_reg (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            issue_fire,
    input  logic                            lsu_rdy,
    input  logic [exu_pkg::op_w-1:0]        op,
    input  logic                            wb_vld_in,
    input  logic [exu_pkg::reg_addr_w-1:0]  wb_addr_in,
    input  logic [exu_pkg::xlen-1:0]        wb_data_in,
    input  logic [exu_pkg::xlen-1:0]        src2,
    input  logic [exu_pkg::sram_addr_w-1:0] sram_addr_in,
    input  logic                            ld_iram_in,
    input  logic                            ld_wram_in,
    input  logic                            ld_oram_in,
    input  logic                            st_iram_in,
    input  logic                            st_wram_in,
    input  logic                            st_oram_in,
    output logic                            lsu_vld,
    output logic                            lsu_wb_vld,
    output logic [exu_pkg::op_w-1:0]        lsu_op,
    output logic [exu_pkg::reg_addr_w-1:0]  lsu_wb_addr,
    output logic [exu_pkg::xlen-1:0]        lsu_wb_data,
    output logic [exu_pkg::xlen-1:0]        lsu_st_data,
    output logic [exu_pkg::sram_addr_w-1:0] lsu_sram_addr,
    output logic                            lsu_ld_iram,
    output logic                            lsu_ld_wram,
    output logic                            lsu_ld_oram,
    output logic                            lsu_st_iram,
    output logic                            lsu_st_wram,
    output logic                            lsu_st_oram
);

    // valid flags hold while the lsu stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            lsu_vld    <= 1'b0;
            lsu_wb_vld <= 1'b0;
        end else if (issue_fire) begin
            lsu_vld    <= ~exu_pkg::is_branch(op);
            lsu_wb_vld <= wb_vld_in;
        end else if (lsu_rdy) begin
            lsu_vld    <= 1'b0;
            lsu_wb_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            lsu_op        <= op;
            lsu_wb_addr   <= wb_addr_in;
            lsu_wb_data   <= wb_data_in;
            lsu_st_data   <= src2;
            lsu_sram_addr <= sram_addr_in;
            lsu_ld_iram   <= ld_iram_in;
            lsu_ld_wram   <= ld_wram_in;
            lsu_ld_oram   <= ld_oram_in;
            lsu_st_iram   <= st_iram_in;
            lsu_st_wram   <= st_wram_in;
            lsu_st_oram   <= st_oram_in;
        end
    end

endmodule

// ==== rtl/exu_branch_unit.sv ====
`timescale 1ns/10ps

module exu_branch_unit #(
    parameter int redirect_w = 12
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issue_vld,
    input  logic                     lsu_rdy,
    input  logic [exu_pkg::op_w-1:0] op,
    input  logic [exu_pkg::xlen-1:0] src1,
    input  logic [exu_pkg::xlen-1:0] src2,
    input  logic [exu_pkg::xlen-1:0] imm,
    input  logic [exu_pkg::xlen-1:0] pc,
    output logic                     issue_fire,
    output logic                     redirect_vld,
    output logic [redirect_w-1:0]    redirect_addr
);

    logic                     lt_s;
    logic                     lt_u;
    logic                     eq;
    logic                     taken;
    logic [exu_pkg::xlen-1:0] target;

    // instruction arriving with a redirect is dropped
    assign issue_fire = issue_vld & lsu_rdy & ~redirect_vld;

    assign eq   = src1 == src2;
    assign lt_s = $signed(src1) < $signed(src2);
    assign lt_u = src1 < src2;

    always_comb begin
        taken = 1'b0;
        case (op)
            exu_pkg::op_beq:  taken = eq;
            exu_pkg::op_bne:  taken = ~eq;
            exu_pkg::op_blt:  taken = lt_s;
            exu_pkg::op_bge:  taken = ~lt_s;
            exu_pkg::op_bltu: taken = lt_u;
            exu_pkg::op_bgeu: taken = ~lt_u;
            exu_pkg::op_jal,
            exu_pkg::op_jalr: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        if (op == exu_pkg::op_jal) begin
            target = pc + src2;
        end else if (op == exu_pkg::op_jalr) begin
            target = src1 + src2;
        end else begin
            target = pc + imm;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_vld <= 1'b0;
        end else begin
            redirect_vld <= issue_fire & taken;
        end
    end

    // only meaningful while redirect_vld is high
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            redirect_addr <= target[redirect_w-1:0];
        end
    end

endmodule

// ==== rtl/exu_agu.sv ====
`timescale 1ns/10ps

module exu_agu (
    input  logic [exu_pkg::op_w-1:0]        op,
    input  logic [exu_pkg::xlen-1:0]        src1,
    input  logic [exu_pkg::xlen-1:0]        src2,
    input  logic [exu_pkg::xlen-1:0]        imm,
    output logic [exu_pkg::sram_addr_w-1:0] sram_addr,
    output logic                            ld_iram,
    output logic                            ld_wram,
    output logic                            ld_oram,
    output logic                            st_iram,
    output logic                            st_wram,
    output logic                            st_oram
);

    logic               ld_op;
    logic               st_op;
    exu_pkg::eff_word_u eff;

    assign ld_op = exu_pkg::is_load(op);
    assign st_op = exu_pkg::is_store(op);

    // loads take src2, stores the immediate
    assign eff.raw = src1 + (st_op ? imm : src2);

    assign sram_addr = eff.mem.offset;

    assign ld_iram = ld_op & (eff.mem.sram_type == exu_pkg::sram_iram);
    assign ld_wram = ld_op & (eff.mem.sram_type == exu_pkg::sram_wram);
    assign ld_oram = ld_op & (eff.mem.sram_type == exu_pkg::sram_oram);
    assign st_iram = st_op & (eff.mem.sram_type == exu_pkg::sram_iram);
    assign st_wram = st_op & (eff.mem.sram_type == exu_pkg::sram_wram);
    assign st_oram = st_op & (eff.mem.sram_type == exu_pkg::sram_oram);

endmodule

// ==== rtl/exu_int_alu.sv ====
`timescale 1ns/10ps

module exu_int_alu (
    input  logic [exu_pkg::op_w-1:0] op,
    input  logic [exu_pkg::xlen-1:0] src1,
    input  logic [exu_pkg::xlen-1:0] src2,
    input  logic [exu_pkg::xlen-1:0] pc,
    output exu_pkg::eff_word_u       wb_data
);

    logic [exu_pkg::xlen-1:0] sum;
    logic [exu_pkg::xlen-1:0] diff;
    logic [exu_pkg::xlen-1:0] auipc_sum;
    logic [exu_pkg::xlen-1:0] link_pc;
    logic [exu_pkg::xlen-1:0] sra_rlt;
    logic [4:0]               shamt;
    logic                     lt_s;
    logic                     lt_u;

    assign sum       = src1 + src2;
    assign diff      = src1 - src2;
    assign auipc_sum = pc + src2;
    assign link_pc   = pc + 32'd4;

    // only the low five bits count as shift amount
    assign shamt   = src2[4:0];
    assign sra_rlt = $unsigned($signed(src1) >>> shamt);

    // signed compare holds across differing signs
    assign lt_s = $signed(src1) < $signed(src2);
    assign lt_u = src1 < src2;

    always_comb begin
        wb_data.raw = '0;
        case (op)
            exu_pkg::op_add:   wb_data.raw = sum;
            exu_pkg::op_sub:   wb_data.raw = diff;
            exu_pkg::op_slt:   wb_data.raw = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
            exu_pkg::op_sltu:  wb_data.raw = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
            exu_pkg::op_xor:   wb_data.raw = src1 ^ src2;
            exu_pkg::op_or:    wb_data.raw = src1 | src2;
            exu_pkg::op_and:   wb_data.raw = src1 & src2;
            exu_pkg::op_sll:   wb_data.raw = src1 << shamt;
            exu_pkg::op_srl:   wb_data.raw = src1 >> shamt;
            exu_pkg::op_sra:   wb_data.raw = sra_rlt;
            // immediate already shifted by decode
            exu_pkg::op_lui:   wb_data.raw = src2;
            exu_pkg::op_auipc: wb_data.raw = auipc_sum;
            exu_pkg::op_jal,
            exu_pkg::op_jalr:  wb_data.raw = link_pc;
            default:           wb_data.raw = '0;
        endcase
    end

endmodule

// ==== rtl/exu_pkg.sv ====
package exu_pkg;

    localparam int xlen          = 32;
    localparam int reg_addr_w    = 5;
    localparam int sram_addr_w   = 13;
    localparam int sram_type_lsb = 13;
    localparam int op_w          = 5;

    // integer and jump ops
    localparam logic [op_w-1:0] op_add   = 5'd0;
    localparam logic [op_w-1:0] op_sub   = 5'd1;
    localparam logic [op_w-1:0] op_slt   = 5'd2;
    localparam logic [op_w-1:0] op_sltu  = 5'd3;
    localparam logic [op_w-1:0] op_xor   = 5'd4;
    localparam logic [op_w-1:0] op_or    = 5'd5;
    localparam logic [op_w-1:0] op_and   = 5'd6;
    localparam logic [op_w-1:0] op_sll   = 5'd7;
    localparam logic [op_w-1:0] op_srl   = 5'd8;
    localparam logic [op_w-1:0] op_sra   = 5'd9;
    localparam logic [op_w-1:0] op_lui   = 5'd10;
    localparam logic [op_w-1:0] op_auipc = 5'd11;
    localparam logic [op_w-1:0] op_jal   = 5'd12;
    localparam logic [op_w-1:0] op_jalr  = 5'd13;
    // branches
    localparam logic [op_w-1:0] op_beq   = 5'd16;
    localparam logic [op_w-1:0] op_bne   = 5'd17;
    localparam logic [op_w-1:0] op_blt   = 5'd18;
    localparam logic [op_w-1:0] op_bge   = 5'd19;
    localparam logic [op_w-1:0] op_bltu  = 5'd20;
    localparam logic [op_w-1:0] op_bgeu  = 5'd21;
    // loads and stores
    localparam logic [op_w-1:0] op_lb    = 5'd24;
    localparam logic [op_w-1:0] op_lh    = 5'd25;
    localparam logic [op_w-1:0] op_lw    = 5'd26;
    localparam logic [op_w-1:0] op_lbu   = 5'd27;
    localparam logic [op_w-1:0] op_lhu   = 5'd28;
    localparam logic [op_w-1:0] op_sb    = 5'd29;
    localparam logic [op_w-1:0] op_sh    = 5'd30;
    localparam logic [op_w-1:0] op_sw    = 5'd31;

    // type field just above the sram offset
    // code 3 selects no memory
    localparam logic [1:0] sram_iram = 2'd0;
    localparam logic [1:0] sram_oram = 2'd1;
    localparam logic [1:0] sram_wram = 2'd2;

    typedef union packed {
        logic [xlen-1:0] raw;
        struct packed {
            logic [xlen-sram_type_lsb-3:0] upper;
            logic [1:0]                    sram_type;
            logic [sram_addr_w-1:0]        offset;
        } mem;
    } eff_word_u;

    function automatic logic is_load(logic [op_w-1:0] op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    endfunction

    function automatic logic is_store(logic [op_w-1:0] op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    function automatic logic is_branch(logic [op_w-1:0] op);
        return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    endfunction

endpackage
